/* Bender.yml */
package:
  name: timer

sources:
  - logic/timer_pkg.sv
  - logic/timer_bus_pkg.sv
  - logic/timer_prescaler.sv
  - logic/timer_fsm.sv
  - logic/timer_counter.sv
  - logic/timer_wb_regs.sv
  - logic/timer_top.sv
  - target: test
    files:
      - tb/timer_tb.sv

/* logic/timer_bus_pkg.sv */
// Timer bus package
// Wishbone request/response bundles and the register map of the timer
`default_nettype none

package timer_bus_pkg;

    localparam int WB_DATA_W = 32;
    localparam int WB_ADDR_W = 3;

    typedef logic [WB_DATA_W-1:0] wb_data_t;
    typedef logic [WB_ADDR_W-1:0] wb_addr_t;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

    // Word offsets
    localparam wb_addr_t REG_CTRL     = 3'd0;
    localparam wb_addr_t REG_LOAD     = 3'd1;
    localparam wb_addr_t REG_COMPARE  = 3'd2;
    localparam wb_addr_t REG_PRESCALE = 3'd3;
    localparam wb_addr_t REG_COUNT    = 3'd4;
    localparam wb_addr_t REG_STATUS   = 3'd5;

    // CTRL bits
    localparam int CTRL_ENABLE   = 0;
    localparam int CTRL_IE_OVF   = 1;
    localparam int CTRL_IE_MATCH = 2;

    // STATUS bits
    localparam int ST_OVF     = 0;
    localparam int ST_MATCH   = 1;
    localparam int ST_RUNNING = 2;

endpackage

`default_nettype wire

/* logic/timer_counter.sv */
// Timer count register
// Loads on command, counts prescaled ticks and flags compare matches and wraps
`timescale 1ns/1ps
`default_nettype none

module timer_counter (
    input  logic                  clk,
    input  logic                  rst,
    input  timer_pkg::timer_cmd_t cmd,
    input  logic                  tick,
    input  timer_pkg::count_t     load_value,
    input  timer_pkg::count_t     compare_value,
    output timer_pkg::count_t     count,
    output timer_pkg::timer_evt_t evt
);
    import timer_pkg::*;

    count_t count_inc;

    assign count_inc = count + 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
            evt   <= '0;
        end else begin
            evt <= '0;
            if (cmd.load) begin
                count <= load_value;
            end else if (tick && !evt.overflow) begin
                // A tick landing in the overflow cycle would move a finished count
                if (count == COUNT_MAX) begin
                    count        <= '0;
                    evt.overflow <= 1'b1;
                end else begin
                    count     <= count_inc;
                    evt.match <= (count_inc == compare_value);
                end
            end
        end
    end

    a_single_event: assert property (
        @(posedge clk) disable iff (rst) !(evt.match && evt.overflow)
    );

endmodule

`default_nettype wire

/* logic/timer_fsm.sv */
// Timer run control
// Starts a run with one load command, ends it at overflow or when software disables it
`timescale 1ns/1ps
`default_nettype none

module timer_fsm (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    enable,
    input  timer_pkg::timer_evt_t   evt,
    output timer_pkg::timer_cmd_t   cmd,
    output timer_pkg::timer_state_e state
);
    import timer_pkg::*;

    timer_state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (enable) begin
                    state_nxt = RUNNING;
                end
            end
            RUNNING: begin
                // Software stop takes priority over the wrap
                if (!enable) begin
                    state_nxt = IDLE;
                end else if (evt.overflow) begin
                    state_nxt = DONE;
                end
            end
            DONE: begin
                // Wait for software to drop enable before rearming
                if (!enable) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // Commands are registered with the state so they line up with it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            cmd.load <= 1'b0;
            cmd.run  <= 1'b0;
        end else begin
            state    <= state_nxt;
            cmd.load <= (state == IDLE) && (state_nxt == RUNNING);
            cmd.run  <= (state_nxt == RUNNING);
        end
    end

    a_load_on_start: assert property (
        @(posedge clk) disable iff (rst)
        cmd.load |-> (state == RUNNING) && ($past(state) == IDLE)
    );

    a_run_is_running: assert property (
        @(posedge clk) disable iff (rst) cmd.run == (state == RUNNING)
    );

endmodule

`default_nettype wire

/* logic/timer_pkg.sv */
// Timer core package
// Count and prescaler types, run-control states and the control/event bundles
`default_nettype none

package timer_pkg;

    localparam int COUNT_W = 16;
    localparam int PRESC_W = 8;

    typedef logic [COUNT_W-1:0] count_t;
    typedef logic [PRESC_W-1:0] presc_t;

    // Last value before the count wraps
    localparam count_t COUNT_MAX = '1;

    typedef enum logic [1:0] {
        IDLE,
        RUNNING,
        DONE
    } timer_state_e;

    // Issued by the run-control FSM
    typedef struct packed {
        logic load;
        logic run;
    } timer_cmd_t;

    // One-cycle pulses from the counter
    typedef struct packed {
        logic match;
        logic overflow;
    } timer_evt_t;

endpackage

`default_nettype wire

/* logic/timer_prescaler.sv */
// Timer prescaler
// Turns the clock into count ticks, one every divisor plus one running cycles
`timescale 1ns/1ps
`default_nettype none

module timer_prescaler (
    input  logic              clk,
    input  logic              rst,
    input  logic              run,
    input  timer_pkg::presc_t divisor,
    output logic              tick
);
    import timer_pkg::*;

    presc_t presc_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            presc_cnt <= '0;
        end else if (!run) begin
            presc_cnt <= '0;
        end else if (presc_cnt == divisor) begin
            presc_cnt <= '0;
        end else begin
            presc_cnt <= presc_cnt + 1'b1;
        end
    end

    // Tick on the last cycle of each period
    assign tick = run && (presc_cnt == divisor);

    a_no_tick_stopped: assert property (
        @(posedge clk) disable iff (rst) !run |-> !tick
    );

endmodule

`default_nettype wire

/* logic/timer_top.sv */
// Timer peripheral top
// Bus registers, run control, prescaler and counter of the 16-bit timer
`timescale 1ns/1ps
`default_nettype none

module timer_top (
    input  logic                   clk,
    input  logic                   rst,
    input  timer_bus_pkg::wb_req_t wb_req,
    output timer_bus_pkg::wb_rsp_t wb_rsp,
    output logic                   irq
);
    import timer_pkg::*;

    logic         enable;
    logic         tick;
    count_t       load_value;
    count_t       compare_value;
    count_t       count;
    presc_t       divisor;
    timer_cmd_t   cmd;
    timer_evt_t   evt;
    timer_state_e state;

    timer_wb_regs regs0 (
        .clk           (clk),
        .rst           (rst),
        .wb_req        (wb_req),
        .wb_rsp        (wb_rsp),
        .count         (count),
        .evt           (evt),
        .state         (state),
        .enable        (enable),
        .load_value    (load_value),
        .compare_value (compare_value),
        .divisor       (divisor),
        .irq           (irq)
    );

    timer_fsm fsm0 (
        .clk    (clk),
        .rst    (rst),
        .enable (enable),
        .evt    (evt),
        .cmd    (cmd),
        .state  (state)
    );

    timer_prescaler presc0 (
        .clk     (clk),
        .rst     (rst),
        .run     (cmd.run),
        .divisor (divisor),
        .tick    (tick)
    );

    timer_counter cnt0 (
        .clk           (clk),
        .rst           (rst),
        .cmd           (cmd),
        .tick          (tick),
        .load_value    (load_value),
        .compare_value (compare_value),
        .count         (count),
        .evt           (evt)
    );

endmodule

`default_nettype wire

/* logic/timer_wb_regs.sv */
// Timer register block
// Wishbone classic slave for control, load, compare, prescale, count and sticky status
`timescale 1ns/1ps
`default_nettype none

module timer_wb_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  timer_bus_pkg::wb_req_t  wb_req,
    output timer_bus_pkg::wb_rsp_t  wb_rsp,
    input  timer_pkg::count_t       count,
    input  timer_pkg::timer_evt_t   evt,
    input  timer_pkg::timer_state_e state,
    output logic                    enable,
    output timer_pkg::count_t       load_value,
    output timer_pkg::count_t       compare_value,
    output timer_pkg::presc_t       divisor,
    output logic                    irq
);
    import timer_pkg::*;
    import timer_bus_pkg::*;

    logic     ack;
    logic     access;
    logic     wr;
    logic     ie_ovf;
    logic     ie_match;
    logic     st_ovf;
    logic     st_match;
    wb_data_t rdata;
    wb_data_t rdat_q;

    // New access only when no ack is pending
    assign access = wb_req.cyc && wb_req.stb && !ack;
    assign wr     = access && wb_req.we;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack           <= 1'b0;
            rdat_q        <= '0;
            enable        <= 1'b0;
            ie_ovf        <= 1'b0;
            ie_match      <= 1'b0;
            load_value    <= '0;
            compare_value <= '0;
            divisor       <= '0;
        end else begin
            ack <= access;
            if (access) begin
                rdat_q <= rdata;
            end
            if (wr) begin
                case (wb_req.adr)
                    REG_CTRL: begin
                        enable   <= wb_req.dat[CTRL_ENABLE];
                        ie_ovf   <= wb_req.dat[CTRL_IE_OVF];
                        ie_match <= wb_req.dat[CTRL_IE_MATCH];
                    end
                    REG_LOAD:     load_value    <= count_t'(wb_req.dat);
                    REG_COMPARE:  compare_value <= count_t'(wb_req.dat);
                    REG_PRESCALE: divisor       <= presc_t'(wb_req.dat);
                    default: ;
                endcase
            end
        end
    end

    // Sticky flags, an event beats a write-one clear
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st_ovf   <= 1'b0;
            st_match <= 1'b0;
        end else begin
            if (evt.overflow) begin
                st_ovf <= 1'b1;
            end else if (wr && wb_req.adr == REG_STATUS && wb_req.dat[ST_OVF]) begin
                st_ovf <= 1'b0;
            end
            if (evt.match) begin
                st_match <= 1'b1;
            end else if (wr && wb_req.adr == REG_STATUS && wb_req.dat[ST_MATCH]) begin
                st_match <= 1'b0;
            end
        end
    end

    always_comb begin
        rdata = '0;
        case (wb_req.adr)
            REG_CTRL: begin
                rdata[CTRL_ENABLE]   = enable;
                rdata[CTRL_IE_OVF]   = ie_ovf;
                rdata[CTRL_IE_MATCH] = ie_match;
            end
            REG_LOAD:     rdata = wb_data_t'(load_value);
            REG_COMPARE:  rdata = wb_data_t'(compare_value);
            REG_PRESCALE: rdata = wb_data_t'(divisor);
            REG_COUNT:    rdata = wb_data_t'(count);
            REG_STATUS: begin
                rdata[ST_OVF]     = st_ovf;
                rdata[ST_MATCH]   = st_match;
                rdata[ST_RUNNING] = (state == RUNNING);
            end
            default: rdata = '0;
        endcase
    end

    assign wb_rsp.ack = ack;
    assign wb_rsp.dat = rdat_q;

    assign irq = (st_ovf && ie_ovf) || (st_match && ie_match);

    a_ack_single: assert property (
        @(posedge clk) disable iff (rst) ack |=> !ack
    );

endmodule

`default_nettype wire

/* tb/timer_tb.sv */
// Timer testbench
// Replays register accesses and timer runs from the test file and checks the results
`timescale 1ns/1ps
`default_nettype none

module timer_tb;
    import timer_pkg::*;
    import timer_bus_pkg::*;

    localparam int ACK_LIMIT  = 10;
    localparam int POLL_LIMIT = 100000;

    logic    clk;
    logic    rst;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic    irq;

    timer_top dut0 (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .irq    (irq)
    );

    always #50 clk = ~clk;

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("TEST FAILED");
        $fatal(1, "wait expired");
    endtask

    task automatic check_data(input string name, input wb_data_t got, input wb_data_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "count mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    // One Wishbone classic cycle, request held until ack
    task automatic bus_access(input logic we, input wb_addr_t adr, input wb_data_t dat,
                              output wb_data_t rdat);
        int waited;
        @(negedge clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > ACK_LIMIT) begin
                report_timeout("Wishbone ack");
            end
        end while (!wb_rsp.ack);
        rdat = wb_rsp.dat;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic write_reg(input wb_addr_t adr, input wb_data_t dat);
        wb_data_t unused;
        bus_access(1'b1, adr, dat, unused);
    endtask

    task automatic read_reg(input wb_addr_t adr, output wb_data_t dat);
        bus_access(1'b0, adr, '0, dat);
    endtask

    // ie bit 0 enables the overflow irq, bit 1 the match irq
    task automatic run_timer(input count_t load, input count_t cmp, input presc_t div,
                             input logic [1:0] ie, input logic stop);
        wb_data_t ctrl_on;
        wb_data_t rd;
        wb_data_t first;
        logic     exp_match;
        int       polls;
        ctrl_on   = wb_data_t'({ie, 1'b1});
        exp_match = (cmp > load);
        write_reg(REG_CTRL, 32'h0);
        write_reg(REG_STATUS, 32'h3);
        write_reg(REG_LOAD, wb_data_t'(load));
        write_reg(REG_COMPARE, wb_data_t'(cmp));
        write_reg(REG_PRESCALE, wb_data_t'(div));
        write_reg(REG_CTRL, ctrl_on);
        if (stop) begin
            // Let the run move past the load value before stopping it
            polls = 0;
            rd    = '0;
            while (count_t'(rd) <= load) begin
                if (polls == POLL_LIMIT) begin
                    report_timeout("the count to advance");
                end
                read_reg(REG_COUNT, rd);
                polls++;
            end
            write_reg(REG_CTRL, ctrl_on & ~32'h1);
            read_reg(REG_STATUS, rd);
            check_flag("status.running after stop", rd[ST_RUNNING], 1'b0);
            read_reg(REG_COUNT, first);
            // Space the two reads by more than one prescaler period
            repeat (int'(div) + 2) begin
                read_reg(REG_COUNT, rd);
            end
            check_count("count while stopped", count_t'(rd), count_t'(first));
            check_flag("count at or above load", count_t'(first) >= load, 1'b1);
            write_reg(REG_CTRL, ctrl_on);
            read_reg(REG_STATUS, rd);
            check_flag("status.running after restart", rd[ST_RUNNING], 1'b1);
            read_reg(REG_COUNT, rd);
            check_count("count after restart", count_t'(rd), load);
        end
        polls = 0;
        rd    = '0;
        while (!rd[ST_OVF]) begin
            if (polls == POLL_LIMIT) begin
                report_timeout("the overflow flag");
            end
            read_reg(REG_STATUS, rd);
            polls++;
        end
        read_reg(REG_COUNT, rd);
        check_count("count after overflow", count_t'(rd), 16'h0000);
        read_reg(REG_STATUS, rd);
        check_flag("status.running after overflow", rd[ST_RUNNING], 1'b0);
        check_flag("status.match", rd[ST_MATCH], exp_match);
        check_flag("irq", irq, ie[0] | (ie[1] & exp_match));
        write_reg(REG_STATUS, 32'h1 << ST_OVF);
        read_reg(REG_STATUS, rd);
        check_flag("status.ovf after clear", rd[ST_OVF], 1'b0);
        check_flag("status.match after ovf clear", rd[ST_MATCH], exp_match);
        check_flag("irq after ovf clear", irq, ie[1] & exp_match);
        write_reg(REG_STATUS, 32'h1 << ST_MATCH);
        read_reg(REG_STATUS, rd);
        check_flag("status.match after clear", rd[ST_MATCH], 1'b0);
        check_flag("irq after both clears", irq, 1'b0);
        write_reg(REG_CTRL, 32'h0);
    endtask

    initial begin
        int          fd;
        int          n;
        int          ch;
        string       op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] e;
        wb_data_t    rd;
        clk    = 1'b0;
        rst    = 1'b1;
        wb_req = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        fd = $fopen("tb/timer_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test file tb/timer_tests.txt");
            $display("TEST FAILED");
            $fatal(1, "missing test file");
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", op);
            if (n != 1) begin
                break;
            end
            if (op[0] == "#") begin
                // Skip the rest of a comment line
                ch = 0;
                while (ch != "\n" && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else if (op == "W") begin
                n = $fscanf(fd, "%h %h", a, b);
                write_reg(wb_addr_t'(a), b);
            end else if (op == "R") begin
                n = $fscanf(fd, "%h %h", a, b);
                read_reg(wb_addr_t'(a), rd);
                check_data($sformatf("wb_rsp.dat reg %0d", a), rd, b);
            end else if (op == "N") begin
                n = $fscanf(fd, "%h %h %h %h %h", a, b, c, d, e);
                run_timer(count_t'(a), count_t'(b), presc_t'(c), d[1:0], e[0]);
            end else begin
                $display("Unknown command %s in the test file", op);
                $display("TEST FAILED");
                $fatal(1, "bad test file");
            end
        end
        $fclose(fd);
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/timer_tests.txt */
# W addr data | R addr expected | N load compare divisor irq_enables stop
# All fields hex, irq_enables bit 0 is overflow and bit 1 is match
R 0 00000000
R 1 00000000
R 2 00000000
R 3 00000000
R 4 00000000
R 5 00000000
R 6 00000000
R 7 00000000
W 1 abcd1234
R 1 00001234
W 2 ffff5a5a
R 2 00005a5a
W 3 12345678
R 3 00000078
W 0 fffffff6
R 0 00000006
W 4 00001234
R 4 00000000
W 6 ffffffff
R 6 00000000
R 1 00001234
W 0 00000000
N fff0 fff8 3 3 0
N ffe0 ffe0 1 1 0
N fff0 0000 0 2 0
N fff0 0010 1 3 0
N ffff ffff 2 3 0
N ff00 ff80 c8 3 1

/* verilog.f */
logic/timer_pkg.sv
logic/timer_bus_pkg.sv
logic/timer_prescaler.sv
logic/timer_fsm.sv
logic/timer_counter.sv
logic/timer_wb_regs.sv
logic/timer_top.sv
tb/timer_tb.sv
